// ==== gat_dmvm.f ====
rtl/gat_pkg.sv
rtl/gat_wh_bram.sv
rtl/gat_dmvm_regs.sv
rtl/gat_dmvm_seq.sv
rtl/gat_dmvm_tree.sv
rtl/gat_dmvm_coef.sv
rtl/gat_dmvm_top.sv
verif/gat_dmvm_asserts.sv
verif/gat_dmvm_tb.sv

// ==== rtl/gat_dmvm_coef.sv ====
`timescale 1ns/1ps

module gat_dmvm_coef (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                dot_vld_i,
  input  gat_pkg::acc_t       dot_i,
  input  gat_pkg::node_idx_t  node_idx_i,
  input  logic                last_i,
  input  gat_pkg::node_cnt_t  num_nodes_i,
  output gat_pkg::coef_vec_t  coef_o,
  output gat_pkg::node_cnt_t  num_nodes_o,
  output logic                done_o
);

  gat_pkg::acc_t      result_q [gat_pkg::MAX_NODES];
  gat_pkg::acc_t      pair_sum [gat_pkg::MAX_NODES];
  gat_pkg::coef_vec_t coef_d;
  gat_pkg::coef_vec_t coef_q;
  gat_pkg::node_cnt_t num_nodes_q;
  logic               fin_q;
  logic               done_q;

  // result store, one dot product per node
  always_ff @(posedge clk) begin
    if (dot_vld_i) begin
      result_q[node_idx_i] <= dot_i;
    end
  end

  // set once the last result has landed in the store
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fin_q <= 1'b0;
    end else begin
      fin_q <= dot_vld_i & last_i;
    end
  end

  // source dot product plus each node, clamp then scale
  always_comb begin
    for (int i = 0; i < gat_pkg::MAX_NODES; i++) begin
      pair_sum[i] = result_q[0] + result_q[i];
      if (i >= int'(num_nodes_i)) begin
        coef_d[i] = '0;
      end else if (pair_sum[i] < 0) begin
        coef_d[i] = '0;
      end else begin
        coef_d[i] = gat_pkg::coef_t'(pair_sum[i] >>> gat_pkg::ACT_SHIFT);
      end
    end
  end

  // outputs hold until the next sub-graph finishes
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      coef_q      <= '0;
      num_nodes_q <= '0;
      done_q      <= 1'b0;
    end else begin
      done_q <= fin_q;
      if (fin_q) begin
        coef_q      <= coef_d;
        num_nodes_q <= num_nodes_i;
      end
    end
  end

  assign coef_o      = coef_q;
  assign num_nodes_o = num_nodes_q;
  assign done_o      = done_q;

endmodule

// ==== rtl/gat_dmvm_regs.sv ====
`timescale 1ns/1ps

module gat_dmvm_regs (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                a_we_i,
  input  logic [$clog2(gat_pkg::A_DEPTH)-1:0] a_idx_i,
  input  gat_pkg::a_elem_t                    a_data_i,
  input  logic                                base_we_i,
  input  gat_pkg::wh_addr_t                   base_data_i,
  output gat_pkg::a_vec_t                     a_vec_o,
  output gat_pkg::wh_addr_t                   base_addr_o
);

  gat_pkg::a_vec_t   a_vec_q;
  gat_pkg::wh_addr_t base_q;

  // attention weights
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      a_vec_q <= '0;
    end else if (a_we_i) begin
      if (a_idx_i < gat_pkg::HALF_A) begin
        a_vec_q.a_src[a_idx_i] <= a_data_i;
      end else begin
        // upper indices go to the neighbour half
        a_vec_q.a_nbr[a_idx_i - gat_pkg::HALF_A] <= a_data_i;
      end
    end
  end

  // sub-graph base address
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      base_q <= '0;
    end else if (base_we_i) begin
      base_q <= base_data_i;
    end
  end

  assign a_vec_o     = a_vec_q;
  assign base_addr_o = base_q;

endmodule

// ==== rtl/gat_dmvm_seq.sv ====
`timescale 1ns/1ps

module gat_dmvm_seq (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               start_i,
  input  gat_pkg::wh_addr_t  base_addr_i,
  input  gat_pkg::node_cnt_t rd_row_nodes_i,
  input  logic               dot_vld_i,
  output logic               rd_en_o,
  output gat_pkg::wh_addr_t  rd_addr_o,
  output logic               row_vld_o,
  output gat_pkg::node_idx_t node_idx_o,
  output logic               last_o,
  output gat_pkg::node_cnt_t num_nodes_o,
  output logic               busy_o
);

  gat_pkg::seq_state_t state;
  gat_pkg::wh_addr_t   base_q;
  gat_pkg::node_idx_t  node_idx;
  gat_pkg::node_cnt_t  num_nodes;
  logic                fin_wait;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= gat_pkg::IDLE;
      base_q    <= '0;
      node_idx  <= '0;
      num_nodes <= '0;
      fin_wait  <= 1'b0;
    end else begin
      case (state)
        gat_pkg::IDLE: begin
          if (start_i) begin
            base_q   <= base_addr_i;
            node_idx <= '0;
            state    <= gat_pkg::FETCH;
          end
        end
        gat_pkg::FETCH: begin
          state <= gat_pkg::WAIT_ROW;
        end
        gat_pkg::WAIT_ROW: begin
          // count comes from the first row only
          if (node_idx == '0) begin
            num_nodes <= rd_row_nodes_i;
          end
          state <= gat_pkg::COMPUTE;
        end
        gat_pkg::COMPUTE: begin
          if (dot_vld_i) begin
            if (last_o) begin
              state <= gat_pkg::FINISH;
            end else begin
              node_idx <= node_idx + 1'b1;
              state    <= gat_pkg::FETCH;
            end
          end
        end
        gat_pkg::FINISH: begin
          // stay two cycles to cover the store and the coefficient register
          fin_wait <= ~fin_wait;
          if (fin_wait) begin
            state <= gat_pkg::IDLE;
          end
        end
        default: begin
          state <= gat_pkg::IDLE;
        end
      endcase
    end
  end

  assign rd_en_o     = (state == gat_pkg::FETCH);
  assign rd_addr_o   = base_q + gat_pkg::wh_addr_t'(node_idx);
  assign row_vld_o   = (state == gat_pkg::WAIT_ROW);
  assign node_idx_o  = node_idx;
  assign last_o      = (gat_pkg::node_cnt_t'(node_idx) == num_nodes - gat_pkg::node_cnt_t'(1));
  assign num_nodes_o = num_nodes;
  assign busy_o      = (state != gat_pkg::IDLE);

endmodule

// ==== rtl/gat_dmvm_top.sv ====
`timescale 1ns/1ps

module gat_dmvm_top (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                wh_we_i,
  input  gat_pkg::wh_addr_t                   wh_waddr_i,
  input  gat_pkg::wh_row_t                    wh_wdata_i,
  input  logic                                a_we_i,
  input  logic [$clog2(gat_pkg::A_DEPTH)-1:0] a_idx_i,
  input  gat_pkg::a_elem_t                    a_data_i,
  input  logic                                base_we_i,
  input  gat_pkg::wh_addr_t                   base_data_i,
  input  logic                                start_i,
  output logic                                busy_o,
  output logic                                done_o,
  output gat_pkg::node_cnt_t                  num_nodes_o,
  output gat_pkg::coef_vec_t                  coef_o
);

  gat_pkg::a_vec_t    a_vec;
  gat_pkg::wh_addr_t  base_addr;
  gat_pkg::wh_addr_t  rd_addr;
  logic               rd_en;
  gat_pkg::wh_row_t   rd_row;
  logic               row_vld;
  gat_pkg::node_idx_t node_idx;
  logic               last;
  gat_pkg::node_cnt_t seq_num_nodes;
  logic               dot_vld;
  gat_pkg::acc_t      dot;

  gat_dmvm_regs u_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .a_we_i      (a_we_i),
    .a_idx_i     (a_idx_i),
    .a_data_i    (a_data_i),
    .base_we_i   (base_we_i),
    .base_data_i (base_data_i),
    .a_vec_o     (a_vec),
    .base_addr_o (base_addr)
  );

  gat_wh_bram u_bram (
    .clk     (clk),
    .we_i    (wh_we_i),
    .waddr_i (wh_waddr_i),
    .wdata_i (wh_wdata_i),
    .rd_en_i (rd_en),
    .raddr_i (rd_addr),
    .rdata_o (rd_row)
  );

  gat_dmvm_seq u_seq (
    .clk            (clk),
    .rst_n          (rst_n),
    .start_i        (start_i),
    .base_addr_i    (base_addr),
    .rd_row_nodes_i (rd_row.num_nodes),
    .dot_vld_i      (dot_vld),
    .rd_en_o        (rd_en),
    .rd_addr_o      (rd_addr),
    .row_vld_o      (row_vld),
    .node_idx_o     (node_idx),
    .last_o         (last),
    .num_nodes_o    (seq_num_nodes),
    .busy_o         (busy_o)
  );

  gat_dmvm_tree u_tree (
    .clk       (clk),
    .rst_n     (rst_n),
    .row_vld_i (row_vld),
    .row_i     (rd_row),
    .a_vec_i   (a_vec),
    .dot_vld_o (dot_vld),
    .dot_o     (dot)
  );

  gat_dmvm_coef u_coef (
    .clk         (clk),
    .rst_n       (rst_n),
    .dot_vld_i   (dot_vld),
    .dot_i       (dot),
    .node_idx_i  (node_idx),
    .last_i      (last),
    .num_nodes_i (seq_num_nodes),
    .coef_o      (coef_o),
    .num_nodes_o (num_nodes_o),
    .done_o      (done_o)
  );

endmodule

// ==== rtl/gat_dmvm_tree.sv ====
`timescale 1ns/1ps

module gat_dmvm_tree (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             row_vld_i,
  input  gat_pkg::wh_row_t row_i,
  input  gat_pkg::a_vec_t  a_vec_i,
  output logic             dot_vld_o,
  output gat_pkg::acc_t    dot_o
);

  gat_pkg::a_elem_t [gat_pkg::HALF_A-1:0] a_sel;

  gat_pkg::acc_t prod_q [gat_pkg::HALF_A];
  gat_pkg::acc_t sum1_q [gat_pkg::HALF_A/2];
  gat_pkg::acc_t sum2_q [gat_pkg::HALF_A/4];
  gat_pkg::acc_t dot_q;

  // one valid bit per stage: products, level 1, level 2, level 3
  logic [3:0] vld_q;

  // source row uses the source half of a
  assign a_sel = row_i.src_flag ? a_vec_i.a_src : a_vec_i.a_nbr;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[2:0], row_vld_i};
    end
  end

  // multiplier bank
  always_ff @(posedge clk) begin
    if (row_vld_i) begin
      for (int i = 0; i < gat_pkg::HALF_A; i++) begin
        prod_q[i] <= $signed(a_sel[i]) * $signed(row_i.features[i]);
      end
    end
  end

  // level 1, eight to four
  always_ff @(posedge clk) begin
    if (vld_q[0]) begin
      for (int i = 0; i < gat_pkg::HALF_A/2; i++) begin
        sum1_q[i] <= prod_q[2*i] + prod_q[2*i+1];
      end
    end
  end

  // level 2, four to two
  always_ff @(posedge clk) begin
    if (vld_q[1]) begin
      for (int i = 0; i < gat_pkg::HALF_A/4; i++) begin
        sum2_q[i] <= sum1_q[2*i] + sum1_q[2*i+1];
      end
    end
  end

  // level 3, final sum
  always_ff @(posedge clk) begin
    if (vld_q[2]) begin
      dot_q <= sum2_q[0] + sum2_q[1];
    end
  end

  assign dot_vld_o = vld_q[3];
  assign dot_o     = dot_q;

endmodule

// ==== rtl/gat_pkg.sv ====
package gat_pkg;

  // sizes
  localparam int A_DEPTH   = 16;
  localparam int HALF_A    = 8;
  localparam int MAX_NODES = 8;
  localparam int WH_ROWS   = 64;
  localparam int ACT_SHIFT = 12;

  typedef logic signed [7:0]  a_elem_t;
  typedef logic signed [11:0] wh_elem_t;
  // product, tree sum and dot product share one width
  typedef logic signed [19:0] acc_t;
  typedef logic [7:0]         coef_t;
  typedef logic [3:0]         node_cnt_t;
  typedef logic [2:0]         node_idx_t;
  typedef logic [5:0]         wh_addr_t;

  // one ram word, features on top
  typedef struct packed {
    wh_elem_t [HALF_A-1:0] features;
    node_cnt_t             num_nodes;
    logic                  src_flag;
  } wh_row_t;

  // source half and neighbour half of a
  typedef struct packed {
    a_elem_t [HALF_A-1:0] a_src;
    a_elem_t [HALF_A-1:0] a_nbr;
  } a_vec_t;

  typedef coef_t [MAX_NODES-1:0] coef_vec_t;

  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    WAIT_ROW,
    COMPUTE,
    FINISH
  } seq_state_t;

endpackage

// ==== rtl/gat_wh_bram.sv ====
`timescale 1ns/1ps

module gat_wh_bram (
  input  logic              clk,
  input  logic              we_i,
  input  gat_pkg::wh_addr_t waddr_i,
  input  gat_pkg::wh_row_t  wdata_i,
  input  logic              rd_en_i,
  input  gat_pkg::wh_addr_t raddr_i,
  output gat_pkg::wh_row_t  rdata_o
);

  gat_pkg::wh_row_t mem [gat_pkg::WH_ROWS];
  gat_pkg::wh_row_t rdata_q;

  // write port
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // registered read, data one cycle after rd_en
  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      rdata_q <= mem[raddr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// ==== verif/gat_dmvm_asserts.sv ====
`timescale 1ns/1ps

module gat_dmvm_asserts (
  input logic clk,
  input logic rst_n,
  input logic start_i,
  input logic busy_i,
  input logic done_i,
  input logic rd_en_i
);

  // count of failed assertions
  int fail_cnt = 0;

  // done is a single-cycle pulse
  done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    done_i |=> !done_i)
  else begin
    $error("done_o stayed high for more than one cycle");
    fail_cnt++;
  end

  // busy drops only right after done
  busy_fall_after_done: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(busy_i) |-> $past(done_i))
  else begin
    $error("busy_o fell without a preceding done_o");
    fail_cnt++;
  end

  // no ram reads out of idle without a start, and none in the done cycle
  no_read_idle: assert property (@(posedge clk) disable iff (!rst_n)
    rd_en_i |-> (!done_i && ($past(busy_i) || $past(start_i))))
  else begin
    $error("rd_en high while idle");
    fail_cnt++;
  end

  // accepted start issues the first read on the next cycle
  start_to_read: assert property (@(posedge clk) disable iff (!rst_n)
    (start_i && !busy_i) |=> (busy_i && rd_en_i))
  else begin
    $error("accepted start did not issue a read");
    fail_cnt++;
  end

endmodule

// ==== verif/gat_dmvm_tb.sv ====
`timescale 1ns/1ps

module gat_dmvm_tb;

  logic               clk;
  logic               rst_n;
  logic               wh_we_i;
  gat_pkg::wh_addr_t  wh_waddr_i;
  gat_pkg::wh_row_t   wh_wdata_i;
  logic               a_we_i;
  logic [3:0]         a_idx_i;
  gat_pkg::a_elem_t   a_data_i;
  logic               base_we_i;
  gat_pkg::wh_addr_t  base_data_i;
  logic               start_i;
  logic               busy_o;
  logic               done_o;
  gat_pkg::node_cnt_t num_nodes_o;
  gat_pkg::coef_vec_t coef_o;

  // copies of what was written into the DUT
  gat_pkg::wh_row_t   wh_shadow [gat_pkg::WH_ROWS];
  gat_pkg::a_vec_t    a_shadow;
  gat_pkg::coef_vec_t exp_coef;
  gat_pkg::node_cnt_t exp_count;
  gat_pkg::coef_vec_t saved_coef;
  logic [31:0]        seed;
  int                 cmp_runs;
  int                 exp_runs;

  always #5 clk = ~clk;

  gat_dmvm_top dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .wh_we_i     (wh_we_i),
    .wh_waddr_i  (wh_waddr_i),
    .wh_wdata_i  (wh_wdata_i),
    .a_we_i      (a_we_i),
    .a_idx_i     (a_idx_i),
    .a_data_i    (a_data_i),
    .base_we_i   (base_we_i),
    .base_data_i (base_data_i),
    .start_i     (start_i),
    .busy_o      (busy_o),
    .done_o      (done_o),
    .num_nodes_o (num_nodes_o),
    .coef_o      (coef_o)
  );

  bind gat_dmvm_top gat_dmvm_asserts u_asserts (
    .clk     (clk),
    .rst_n   (rst_n),
    .start_i (start_i),
    .busy_i  (busy_o),
    .done_i  (done_o),
    .rd_en_i (rd_en)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // expected coefficients from source dot plus node dot after clamp and divide by 2^12
  function automatic gat_pkg::coef_vec_t ref_coefs(
    input  gat_pkg::a_vec_t    av,
    input  gat_pkg::wh_row_t   rows [gat_pkg::WH_ROWS],
    input  gat_pkg::wh_addr_t  base,
    output gat_pkg::node_cnt_t cnt
  );
    gat_pkg::acc_t      dots [gat_pkg::MAX_NODES];
    gat_pkg::coef_vec_t res;
    gat_pkg::wh_row_t   row;
    gat_pkg::a_elem_t   w8;
    gat_pkg::wh_elem_t  f12;
    gat_pkg::acc_t      pair;
    int                 sum;
    cnt = rows[base].num_nodes;
    res = '0;
    for (int n = 0; n < gat_pkg::MAX_NODES; n++) begin
      dots[n] = '0;
      if (n < int'(cnt)) begin
        row = rows[gat_pkg::wh_addr_t'(int'(base) + n)];
        sum = 0;
        for (int k = 0; k < gat_pkg::HALF_A; k++) begin
          w8  = row.src_flag ? av.a_src[k] : av.a_nbr[k];
          f12 = row.features[k];
          sum += int'(w8) * int'(f12);
        end
        // dot products live in 20 bits
        dots[n] = gat_pkg::acc_t'(sum);
      end
    end
    for (int n = 0; n < gat_pkg::MAX_NODES; n++) begin
      if (n < int'(cnt)) begin
        pair = gat_pkg::acc_t'(int'(dots[0]) + int'(dots[n]));
        if (pair >= 0) begin
          res[n] = gat_pkg::coef_t'(int'(pair) / 4096);
        end
      end
    end
    return res;
  endfunction

  task automatic rand_word(output logic [31:0] r);
    seed = lcg_next(seed);
    r = seed;
  endtask

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic fail_now();
    $display("Checks failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_coef(input gat_pkg::coef_t got, input gat_pkg::coef_t want,
                            input int idx);
    if (got !== want) begin
      $display("FAIL t=%0t coef_o[%0d] is %0d, expected %0d", $time, idx, got, want);
      fail_now();
    end
  endtask

  task automatic check_count(input gat_pkg::node_cnt_t got, input gat_pkg::node_cnt_t want);
    if (got !== want) begin
      $display("FAIL t=%0t num_nodes_o is %0d, expected %0d", $time, got, want);
      fail_now();
    end
  endtask

  task automatic check_flag(input logic got, input logic want, input string name);
    if (got !== want) begin
      $display("FAIL t=%0t %s is %b, expected %b", $time, name, got, want);
      fail_now();
    end
  endtask

  task automatic check_done_count();
    if (cmp_runs != exp_runs) begin
      $display("FAIL t=%0t saw %0d done_o pulses, expected %0d", $time, cmp_runs, exp_runs);
      fail_now();
    end
  endtask

  task automatic load_row(input gat_pkg::wh_addr_t addr, input gat_pkg::wh_row_t row);
    wh_we_i    = 1'b1;
    wh_waddr_i = addr;
    wh_wdata_i = row;
    step();
    wh_we_i = 1'b0;
    wh_shadow[addr] = row;
  endtask

  task automatic load_weight(input int idx, input gat_pkg::a_elem_t w);
    a_we_i   = 1'b1;
    a_idx_i  = 4'(idx);
    a_data_i = w;
    step();
    a_we_i = 1'b0;
    if (idx < gat_pkg::HALF_A) begin
      a_shadow.a_src[idx] = w;
    end else begin
      a_shadow.a_nbr[idx - gat_pkg::HALF_A] = w;
    end
  endtask

  task automatic load_weights(input logic use_rand, input gat_pkg::a_elem_t src_w,
                              input gat_pkg::a_elem_t nbr_w);
    logic [31:0] r;
    for (int i = 0; i < gat_pkg::A_DEPTH; i++) begin
      rand_word(r);
      if (use_rand) begin
        load_weight(i, r[31:24]);
      end else begin
        load_weight(i, (i < gat_pkg::HALF_A) ? src_w : nbr_w);
      end
    end
  endtask

  task automatic fill_subgraph(input int base, input int n, input logic use_rand,
                               input gat_pkg::wh_elem_t feat);
    gat_pkg::wh_row_t row;
    logic [31:0]      r;
    for (int i = 0; i < n; i++) begin
      for (int k = 0; k < gat_pkg::HALF_A; k++) begin
        rand_word(r);
        row.features[k] = use_rand ? gat_pkg::wh_elem_t'(r[27:16]) : feat;
      end
      rand_word(r);
      // count field of later rows is noise
      row.num_nodes = (i == 0) ? gat_pkg::node_cnt_t'(n) : gat_pkg::node_cnt_t'(r[19:16]);
      row.src_flag  = (i == 0);
      load_row(gat_pkg::wh_addr_t'(base + i), row);
    end
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    while (done_o !== 1'b1) begin
      if (n == 500) begin
        $display("timeout: done_o did not pulse after start");
        fail_now();
      end
      step();
      n++;
    end
    // one more cycle so the compare process sees the pulse
    step();
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (busy_o !== 1'b0) begin
      if (n == 500) begin
        $display("timeout: busy_o stayed high");
        fail_now();
      end
      step();
      n++;
    end
  endtask

  task automatic run_subgraph(input int base, input logic extra_start);
    base_we_i   = 1'b1;
    base_data_i = gat_pkg::wh_addr_t'(base);
    step();
    base_we_i = 1'b0;
    exp_coef  = ref_coefs(a_shadow, wh_shadow, gat_pkg::wh_addr_t'(base), exp_count);
    exp_runs++;
    start_i = 1'b1;
    step();
    start_i = 1'b0;
    if (extra_start) begin
      repeat (10) step();
      check_flag(busy_o, 1'b1, "busy_o");
      start_i = 1'b1;
      step();
      start_i = 1'b0;
    end
    wait_done();
    wait_idle();
    check_done_count();
  endtask

  // compare every done pulse against the model
  always @(negedge clk) begin
    if (rst_n === 1'b1 && done_o === 1'b1) begin
      cmp_runs++;
      for (int i = 0; i < gat_pkg::MAX_NODES; i++) begin
        check_coef(coef_o[i], exp_coef[i], i);
      end
      check_count(num_nodes_o, exp_count);
    end
    if (dut0.u_asserts.fail_cnt != 0) begin
      $display("a concurrent assertion on the DUT failed");
      fail_now();
    end
  end

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    wh_we_i     = 1'b0;
    wh_waddr_i  = '0;
    wh_wdata_i  = '0;
    a_we_i      = 1'b0;
    a_idx_i     = '0;
    a_data_i    = '0;
    base_we_i   = 1'b0;
    base_data_i = '0;
    start_i     = 1'b0;
    seed        = 32'hae73;
    cmp_runs    = 0;
    exp_runs    = 0;
    a_shadow    = '0;
    exp_coef    = '0;
    exp_count   = '0;
    for (int i = 0; i < gat_pkg::WH_ROWS; i++) begin
      wh_shadow[i] = '0;
    end
    step();
    step();
    rst_n = 1'b1;

    // outputs after reset
    for (int i = 0; i < gat_pkg::MAX_NODES; i++) begin
      check_coef(coef_o[i], '0, i);
    end
    check_count(num_nodes_o, '0);
    check_flag(busy_o, 1'b0, "busy_o");
    check_flag(done_o, 1'b0, "done_o");

    // random five-node sub-graph at base 0
    load_weights(1'b1, '0, '0);
    fill_subgraph(0, 5, 1'b1, '0);
    run_subgraph(0, 1'b0);
    for (int i = 5; i < gat_pkg::MAX_NODES; i++) begin
      check_coef(coef_o[i], '0, i);
    end
    saved_coef = coef_o;

    // second start while busy is dropped
    run_subgraph(0, 1'b1);
    repeat (80) step();
    check_done_count();
    check_flag(busy_o, 1'b0, "busy_o");
    for (int i = 0; i < gat_pkg::MAX_NODES; i++) begin
      check_coef(coef_o[i], saved_coef[i], i);
    end

    // negative sums clamp to zero, positive ones keep the upper bits
    load_weights(1'b0, -8'sd50, -8'sd40);
    fill_subgraph(16, 4, 1'b0, 12'sd500);
    run_subgraph(16, 1'b0);
    load_weights(1'b0, 8'sd60, 8'sd50);
    run_subgraph(16, 1'b0);
    check_coef(coef_o[0], 8'd117, 0);
    check_coef(coef_o[1], 8'd107, 1);

    // back to back with eight nodes and then one node with new weights
    load_weights(1'b1, '0, '0);
    fill_subgraph(24, 8, 1'b1, '0);
    run_subgraph(24, 1'b0);
    load_weights(1'b1, '0, '0);
    fill_subgraph(40, 1, 1'b1, '0);
    run_subgraph(40, 1'b0);
    for (int i = 1; i < gat_pkg::MAX_NODES; i++) begin
      check_coef(coef_o[i], '0, i);
    end

    if (cmp_runs == exp_runs && exp_runs == 6) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("compared %0d sub-graphs, expected 6", cmp_runs);
      $display("Checks failed");
      $fatal(1, "wrong number of completed sub-graphs");
    end
  end

endmodule
